// ==== Bender.yml ====
package:
  name: game_logic

sources:
  - design/game_types_pkg.sv
  - design/game_rules_pkg.sv
  - design/judge_if.sv
  - design/outcome_if.sv
  - design/chart_decode.sv
  - design/slice_judge.sv
  - design/game_state.sv
  - design/game_logic_top.sv
  - target: test
    files:
      - verif/game_logic_sva.sv
      - verif/game_logic_tb.sv

// ==== all.f ====
design/game_types_pkg.sv
design/game_rules_pkg.sv
design/judge_if.sv
design/outcome_if.sv
design/chart_decode.sv
design/slice_judge.sv
design/game_state.sv
design/game_logic_top.sv
verif/game_logic_sva.sv
verif/game_logic_tb.sv

// ==== design/chart_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module chart_decode (
    input  logic                              clk_in,
    input  logic                              rst_n,
    input  logic                              chart_strobe,
    input  game_types_pkg::chart_word_u       chart_word,
    input  logic [game_rules_pkg::TIME_W-1:0] curr_time,
    output logic                              chart_full,
    judge_if.decode_mp                        jdg
);
    import game_types_pkg::*;
    import game_rules_pkg::*;

    chart_word_u             slot_word [BLOCK_SLOTS];
    logic [BLOCK_SLOTS-1:0]  slot_filled;
    logic [SLOT_W-1:0]       scan_ptr;

    logic                    free_found;
    logic [SLOT_W-1:0]       free_idx;
    logic                    load_en;
    logic                    due;

    //////////////////////////////////////////////////////////////////////
    // Free slot finder
    //////////////////////////////////////////////////////////////////////

    // Walk down so the lowest free slot wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = BLOCK_SLOTS - 1; i >= 0; i--) begin
            if (!slot_filled[i]) begin
                free_found = 1'b1;
                free_idx   = SLOT_W'(i);
            end
        end
    end

    assign load_en    = chart_strobe && free_found;
    assign chart_full = &slot_filled;

    //////////////////////////////////////////////////////////////////////
    // Round-robin release scan
    //////////////////////////////////////////////////////////////////////

    // Hit time read through the note view, walls share the position
    assign due = slot_filled[scan_ptr] &&
                 (slot_word[scan_ptr].note.hit_time == curr_time);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            slot_filled <= '0;
            scan_ptr    <= '0;
            jdg.issue   <= 1'b0;
        end else begin
            jdg.issue <= due;

            // Load and release never touch the same slot
            if (load_en) begin
                slot_filled[free_idx] <= 1'b1;
            end
            if (due) begin
                slot_filled[scan_ptr] <= 1'b0;
            end

            if (scan_ptr == SLOT_W'(BLOCK_SLOTS - 1)) begin
                scan_ptr <= '0;
            end else begin
                scan_ptr <= scan_ptr + 1'b1;
            end
        end
    end

    // Slot contents and released word
    always_ff @(posedge clk_in) begin
        if (load_en) begin
            slot_word[free_idx] <= chart_word;
        end
        if (due) begin
            jdg.entry <= slot_word[scan_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== design/game_logic_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_logic_top (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic                                chart_strobe,
    input  logic [31:0]                         chart_word,
    input  logic                                frame_tick,
    input  logic [1:0]                          saber_lane_x,
    input  logic [1:0]                          saber_lane_y,
    input  logic [2:0]                          swing_dir,
    input  logic [1:0]                          head_lane,
    output logic                                chart_full,
    output logic [game_rules_pkg::TIME_W-1:0]   curr_time,
    output logic [game_rules_pkg::SCORE_W-1:0]  score,
    output logic [game_rules_pkg::COMBO_W-1:0]  combo,
    output logic [game_rules_pkg::HEALTH_W-1:0] health,
    output logic                                game_over
);
    import game_types_pkg::*;

    swing_dir_e swing_dir_w;

    assign swing_dir_w = swing_dir_e'(swing_dir);

    //////////////////////////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////////////////////////

    judge_if   jdg_bus ();
    outcome_if res_bus ();

    // Decode, then judge, then bookkeeping; game time loops back
    chart_decode u_decode (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .chart_strobe (chart_strobe),
        .chart_word   (chart_word),
        .curr_time    (curr_time),
        .chart_full   (chart_full),
        .jdg          (jdg_bus.decode_mp)
    );

    slice_judge u_judge (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .saber_lane_x (saber_lane_x),
        .saber_lane_y (saber_lane_y),
        .swing_dir    (swing_dir_w),
        .head_lane    (head_lane),
        .jdg          (jdg_bus.execute_mp),
        .res          (res_bus.execute_mp)
    );

    game_state u_state (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .frame_tick   (frame_tick),
        .res          (res_bus.result_mp),
        .curr_time    (curr_time),
        .score        (score),
        .combo        (combo),
        .health       (health),
        .game_over    (game_over)
    );

endmodule

`default_nettype wire

// ==== design/game_rules_pkg.sv ====
`default_nettype none

package game_rules_pkg;

    //////////////////////////////////////////////////////////////////////
    // Chart table and time base
    //////////////////////////////////////////////////////////////////////

    localparam int BLOCK_SLOTS = 4;
    localparam int SLOT_W      = $clog2(BLOCK_SLOTS);
    localparam int TIME_W      = 12;

    //////////////////////////////////////////////////////////////////////
    // Scoring
    //////////////////////////////////////////////////////////////////////

    localparam int SCORE_W     = 16;
    localparam int COMBO_W     = 3;
    localparam int BASE_POINTS = 10;
    localparam int MAX_COMBO   = 7;
    // Multiplier is combo + 1, capped here
    localparam int MAX_MULT    = 4;

    //////////////////////////////////////////////////////////////////////
    // Health
    //////////////////////////////////////////////////////////////////////

    localparam int HEALTH_W     = 4;
    localparam int MAX_HEALTH   = 8;
    localparam int MISS_PENALTY = 1;
    localparam int WALL_PENALTY = 2;

endpackage

`default_nettype wire

// ==== design/game_state.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_state (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic                                frame_tick,
    outcome_if.result_mp                        res,
    output logic [game_rules_pkg::TIME_W-1:0]   curr_time,
    output logic [game_rules_pkg::SCORE_W-1:0]  score,
    output logic [game_rules_pkg::COMBO_W-1:0]  combo,
    output logic [game_rules_pkg::HEALTH_W-1:0] health,
    output logic                                game_over
);
    import game_types_pkg::*;
    import game_rules_pkg::*;

    game_phase_e          phase;
    logic [COMBO_W:0]     combo_inc;
    logic [COMBO_W:0]     mult;
    logic [SCORE_W-1:0]   points;
    logic [HEALTH_W-1:0]  penalty;
    logic [HEALTH_W-1:0]  health_dec;

    //////////////////////////////////////////////////////////////////////
    // Score and health arithmetic
    //////////////////////////////////////////////////////////////////////

    // Multiplier from the combo held before this hit
    always_comb begin
        combo_inc = {1'b0, combo} + 1'b1;
        if (combo_inc > (COMBO_W + 1)'(MAX_MULT)) begin
            mult = (COMBO_W + 1)'(MAX_MULT);
        end else begin
            mult = combo_inc;
        end
        points = SCORE_W'(BASE_POINTS * mult);
    end

    // Health bottoms out at zero
    always_comb begin
        penalty = res.wall_hit ? HEALTH_W'(WALL_PENALTY) : HEALTH_W'(MISS_PENALTY);
        if (health > penalty) begin
            health_dec = health - penalty;
        end else begin
            health_dec = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PLAYING;
            curr_time <= '0;
            score     <= '0;
            combo     <= '0;
            health    <= HEALTH_W'(MAX_HEALTH);
        end else if (phase == PLAYING) begin
            // Time and outcomes both freeze once the game is over
            if (frame_tick) begin
                curr_time <= curr_time + 1'b1;
            end
            if (res.hit) begin
                score <= score + points;
                if (combo != COMBO_W'(MAX_COMBO)) begin
                    combo <= combo_inc[COMBO_W-1:0];
                end
            end else if (res.miss || res.wall_hit) begin
                combo  <= '0;
                health <= health_dec;
                if (health_dec == '0) begin
                    phase <= GAME_OVER;
                end
            end
        end
    end

    assign game_over = (phase == GAME_OVER);

endmodule

`default_nettype wire

// ==== design/game_types_pkg.sv ====
`default_nettype none

package game_types_pkg;

    localparam int BLOCK_ID_W = 8;

    // Swing direction asked for by a note
    typedef enum logic [2:0] {
        ANY   = 3'd0,
        UP    = 3'd1,
        DOWN  = 3'd2,
        LEFT  = 3'd3,
        RIGHT = 3'd4
    } swing_dir_e;

    typedef enum logic {
        PLAYING   = 1'b0,
        GAME_OVER = 1'b1
    } game_phase_e;

    // Note block, kind = 0
    typedef struct packed {
        logic                  kind;
        logic                  color;      // 0 left saber, 1 right saber
        swing_dir_e            direction;
        logic [1:0]            lane_x;
        logic [1:0]            lane_y;
        logic [11:0]           hit_time;
        logic [BLOCK_ID_W-1:0] block_id;
        logic [2:0]            reserved;
    } note_view_t;

    // Wall obstacle, kind = 1
    // hit_time sits at bits 22:11 just like the note view
    typedef struct packed {
        logic        kind;
        logic [1:0]  lane_lo;
        logic [1:0]  lane_hi;
        logic [3:0]  reserved_hi;
        logic [11:0] hit_time;
        logic [10:0] reserved_lo;
    } wall_view_t;

    typedef union packed {
        note_view_t note;
        wall_view_t wall;
    } chart_word_u;

endpackage

`default_nettype wire

// ==== design/judge_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Released chart entry, decode to execute
interface judge_if;
    import game_types_pkg::*;

    logic        issue;
    chart_word_u entry;

    modport decode_mp (
        output issue,
        output entry
    );

    modport execute_mp (
        input issue,
        input entry
    );

endinterface

`default_nettype wire

// ==== design/outcome_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Judged outcome, execute to result
interface outcome_if;
    import game_types_pkg::*;

    logic                  hit;
    logic                  miss;
    logic                  wall_hit;
    logic [BLOCK_ID_W-1:0] block_id;

    modport execute_mp (
        output hit, miss, wall_hit,
        output block_id
    );

    modport result_mp (
        input hit, miss, wall_hit,
        input block_id
    );

endinterface

`default_nettype wire

// ==== design/slice_judge.sv ====
`timescale 1ns/1ns
`default_nettype none

module slice_judge (
    input  logic                       clk_in,
    input  logic                       rst_n,
    input  logic [1:0]                 saber_lane_x,
    input  logic [1:0]                 saber_lane_y,
    input  game_types_pkg::swing_dir_e swing_dir,
    input  logic [1:0]                 head_lane,
    judge_if.execute_mp                jdg,
    outcome_if.execute_mp              res
);
    import game_types_pkg::*;

    chart_word_u word;
    logic        is_wall;
    logic        lane_match;
    logic        dir_match;
    logic        note_match;
    logic        head_in_wall;

    assign word    = jdg.entry;
    assign is_wall = word.wall.kind;

    //////////////////////////////////////////////////////////////////////
    // Note and wall decode
    //////////////////////////////////////////////////////////////////////

    assign lane_match = (saber_lane_x == word.note.lane_x) &&
                        (saber_lane_y == word.note.lane_y);

    // ANY accepts every swing
    assign dir_match  = (word.note.direction == ANY) ||
                        (word.note.direction == swing_dir);

    assign note_match = lane_match && dir_match;

    // Inclusive span check
    assign head_in_wall = (head_lane >= word.wall.lane_lo) &&
                          (head_lane <= word.wall.lane_hi);

    //////////////////////////////////////////////////////////////////////
    // Registered outcome
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            res.hit      <= 1'b0;
            res.miss     <= 1'b0;
            res.wall_hit <= 1'b0;
        end else begin
            res.hit      <= jdg.issue && !is_wall && note_match;
            res.miss     <= jdg.issue && !is_wall && !note_match;
            // A dodged wall gives no pulse at all
            res.wall_hit <= jdg.issue && is_wall && head_in_wall;
        end
    end

    // Walls carry no id
    always_ff @(posedge clk_in) begin
        if (jdg.issue) begin
            res.block_id <= is_wall ? '0 : word.note.block_id;
        end
    end

endmodule

`default_nettype wire

// ==== verif/game_logic_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_logic_sva (
    input logic                                clk_in,
    input logic                                rst_n,
    input logic                                hit,
    input logic                                miss,
    input logic                                wall_hit,
    input logic [game_rules_pkg::SCORE_W-1:0]  score,
    input logic [game_rules_pkg::HEALTH_W-1:0] health
);
    import game_rules_pkg::*;

    int fail_count = 0;

    // At most one outcome per cycle
    outcome_onehot: assert property (
        @(posedge clk_in) disable iff (!rst_n) $onehot0({hit, miss, wall_hit})
    ) else begin
        $error("More than one outcome pulse in the same cycle");
        fail_count++;
    end

    health_bound: assert property (
        @(posedge clk_in) disable iff (!rst_n) health <= HEALTH_W'(MAX_HEALTH)
    ) else begin
        $error("Health rose above its maximum");
        fail_count++;
    end

    // Score moves only on the cycle after a hit
    score_after_hit: assert property (
        @(posedge clk_in) disable iff (!rst_n) $changed(score) |-> $past(hit)
    ) else begin
        $error("Score changed without a hit in the previous cycle");
        fail_count++;
    end

endmodule

bind game_state game_logic_sva u_sva (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .hit      (res.hit),
    .miss     (res.miss),
    .wall_hit (res.wall_hit),
    .score    (score),
    .health   (health)
);

`default_nettype wire

// ==== verif/game_logic_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_logic_tb;
    import game_types_pkg::*;
    import game_rules_pkg::*;

    // About 60 frames of 8 cycles, times six for margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int SETTLE_CYCLES  = BLOCK_SLOTS + 4;

    logic                clk_in;
    logic                rst_n;
    logic                chart_strobe;
    chart_word_u         chart_word;
    logic                frame_tick;
    logic [1:0]          saber_lane_x;
    logic [1:0]          saber_lane_y;
    swing_dir_e          swing_dir;
    logic [1:0]          head_lane;
    logic                chart_full;
    logic [TIME_W-1:0]   curr_time;
    logic [SCORE_W-1:0]  score;
    logic [COMBO_W-1:0]  combo;
    logic [HEALTH_W-1:0] health;
    logic                game_over;

    // Expected game state
    int exp_time;
    int exp_score;
    int exp_combo;
    int exp_health;

    int          error_count;
    int          start_errors;
    int          assert_fails_seen;
    int          test_count;
    int          cycle_count;
    string       test_name;
    logic [16:0] lfsr_state;

    game_logic_top DUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Taps at bits 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[16]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic chart_word_u make_note(input swing_dir_e dir, input logic [1:0] x,
                                              input logic [1:0] y, input int t,
                                              input logic [7:0] id);
        chart_word_u w;
        w                = '0;
        w.note.direction = dir;
        w.note.lane_x    = x;
        w.note.lane_y    = y;
        w.note.hit_time  = 12'(t);
        w.note.block_id  = id;
        return w;
    endfunction

    function automatic chart_word_u make_wall(input logic [1:0] lo, input logic [1:0] hi,
                                              input int t);
        chart_word_u w;
        w              = '0;
        w.wall.kind    = 1'b1;
        w.wall.lane_lo = lo;
        w.wall.lane_hi = hi;
        w.wall.hit_time = 12'(t);
        return w;
    endfunction

    task automatic load_chart(input chart_word_u w);
        @(negedge clk_in);
        chart_strobe = 1'b1;
        chart_word   = w;
        @(negedge clk_in);
        chart_strobe = 1'b0;
    endtask

    // One frame, then room for scan, judge and bookkeeping
    task automatic step_frame();
        @(negedge clk_in);
        frame_tick = 1'b1;
        @(negedge clk_in);
        frame_tick = 1'b0;
        if (exp_health != 0) begin
            exp_time++;
        end
        repeat (SETTLE_CYCLES) @(negedge clk_in);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Expected values and checks
    //////////////////////////////////////////////////////////////////////

    task automatic expect_hit();
        exp_score += BASE_POINTS * ((exp_combo + 1 > MAX_MULT) ? MAX_MULT : exp_combo + 1);
        if (exp_combo < MAX_COMBO) begin
            exp_combo++;
        end
    endtask

    task automatic expect_damage(input int penalty);
        exp_combo  = 0;
        exp_health = (exp_health > penalty) ? exp_health - penalty : 0;
    endtask

    task automatic check_eq(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_state();
        check_eq("curr_time", exp_time, curr_time);
        check_eq("score", exp_score, score);
        check_eq("combo", exp_combo, combo);
        check_eq("health", exp_health, health);
        check_eq("game_over", exp_health == 0, game_over);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_errors = error_count;
    endtask

    task automatic finish_test();
        int new_fails;
        new_fails         = DUT.u_state.u_sva.fail_count - assert_fails_seen;
        assert_fails_seen = DUT.u_state.u_sva.fail_count;
        error_count       += new_fails;
        test_count++;
        if (error_count == start_errors) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d check(s) failed", test_name, error_count - start_errors);
        end
    endtask

    // A due note that the saber meets in random lanes
    task automatic hit_note(input logic use_any);
        logic [1:0] x;
        logic [1:0] y;
        swing_dir_e dir;
        x   = 2'(rand_bits(2));
        y   = 2'(rand_bits(2));
        dir = swing_dir_e'(3'(rand_bits(2) + 1));
        load_chart(make_note(use_any ? ANY : dir, x, y, exp_time + 1, 8'(exp_time)));
        saber_lane_x = x;
        saber_lane_y = y;
        swing_dir    = dir;
        step_frame();
        expect_hit();
        check_state();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        start_test("reset");
        check_eq("chart_full", 0, chart_full);
        check_state();
        step_frame();
        check_state();
        finish_test();
    endtask

    task automatic test_scoring();
        start_test("scoring");
        hit_note(1'b0);
        hit_note(1'b1);
        hit_note(1'b0);
        finish_test();
    endtask

    task automatic test_misses();
        logic [1:0] x;
        logic [1:0] y;
        start_test("misses");
        x = 2'(rand_bits(2));
        y = 2'(rand_bits(2));
        // Right lanes, wrong swing
        load_chart(make_note(UP, x, y, exp_time + 1, 8'd10));
        saber_lane_x = x;
        saber_lane_y = y;
        swing_dir    = DOWN;
        step_frame();
        expect_damage(MISS_PENALTY);
        check_state();
        // Any swing, but one lane off
        load_chart(make_note(ANY, x, y, exp_time + 1, 8'd11));
        saber_lane_x = x ^ 2'd1;
        step_frame();
        expect_damage(MISS_PENALTY);
        check_state();
        finish_test();
    endtask

    task automatic test_walls();
        logic [1:0] h;
        start_test("walls");
        hit_note(1'b1);
        h         = 2'(rand_bits(2));
        head_lane = h;
        load_chart(make_wall(2'd0, h, exp_time + 1));
        step_frame();
        expect_damage(WALL_PENALTY);
        check_state();
        load_chart(make_wall(h ^ 2'd2, h ^ 2'd2, exp_time + 1));
        step_frame();
        check_state();
        finish_test();
    endtask

    task automatic test_overflow();
        logic [1:0] x;
        logic [1:0] y;
        start_test("overflow");
        head_lane = 2'd0;
        for (int k = 1; k <= BLOCK_SLOTS; k++) begin
            load_chart(make_wall(2'd3, 2'd3, exp_time + k));
        end
        check_eq("chart_full", 1, chart_full);
        x = 2'(rand_bits(2));
        y = 2'(rand_bits(2));
        load_chart(make_note(ANY, x, y, exp_time + BLOCK_SLOTS + 1, 8'd50));
        saber_lane_x = x;
        saber_lane_y = y;
        check_eq("chart_full", 1, chart_full);
        step_frame();
        check_eq("chart_full", 0, chart_full);
        repeat (BLOCK_SLOTS) step_frame();
        check_state();
        finish_test();
    endtask

    task automatic test_game_over();
        logic [1:0] x;
        logic [1:0] y;
        start_test("game_over");
        head_lane = 2'd1;
        while (exp_health != 0) begin
            load_chart(make_wall(2'd0, 2'd3, exp_time + 1));
            step_frame();
            expect_damage(WALL_PENALTY);
            check_state();
        end
        // Time is frozen, so a note stamped now is due at once
        x = 2'(rand_bits(2));
        y = 2'(rand_bits(2));
        saber_lane_x = x;
        saber_lane_y = y;
        load_chart(make_note(ANY, x, y, exp_time, 8'd60));
        step_frame();
        check_state();
        finish_test();
    endtask

    initial begin
        rst_n             = 1'b0;
        chart_strobe      = 1'b0;
        chart_word        = '0;
        frame_tick        = 1'b0;
        saber_lane_x      = 2'd0;
        saber_lane_y      = 2'd0;
        swing_dir         = ANY;
        head_lane         = 2'd0;
        lfsr_state        = 17'd99262;
        error_count       = 0;
        start_errors      = 0;
        assert_fails_seen = 0;
        test_count        = 0;
        exp_time          = 0;
        exp_score         = 0;
        exp_combo         = 0;
        exp_health        = MAX_HEALTH;
        repeat (3) @(negedge clk_in);
        rst_n = 1'b1;

        test_reset();
        test_scoring();
        test_misses();
        test_walls();
        test_overflow();
        test_game_over();

        $display("Tests run: %0d, failed checks: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
